// ==== rtl/sys_macros.svh ====
/*
 * Address map and RAM geometry of the simple system.
 * Included by every RTL module that decodes addresses or sizes the banks.
 */
`ifndef SYS_MACROS_SVH
`define SYS_MACROS_SVH

// RAM region, one bank per kB starting at the base
`define RAM_BASE          32'h0010_0000
`define NUM_RAM_BANKS     4
`define BANK_WORDS        256
`define BANK_BYTES        (`BANK_WORDS * 4)

// Simulation control block, 1 kB region
`define SIMCTRL_BASE      32'h0002_0000
`define SIMCTRL_SIZE      1024

// Register offsets inside the control block
`define SIMCTRL_CHAR_OFS  32'h0
`define SIMCTRL_HALT_OFS  32'h8

`endif

// ==== rtl/sys_pkg.sv ====
/*
 * Bus structs and host/target enums shared by the system and its testbench.
 */
package sys_pkg;

  // Bus hosts, data port has priority
  typedef enum logic {
    HostD = 1'b0,
    HostI = 1'b1
  } host_e;

  // Target class of a decoded address
  typedef enum logic [1:0] {
    TgtRam     = 2'd0,
    TgtSimCtrl = 2'd1,
    TgtNone    = 2'd2
  } target_e;

  typedef struct packed {
    logic        req;
    logic [31:0] addr;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } host_req_t;

  typedef struct packed {
    logic        gnt;
    logic        rvalid;
    logic [31:0] rdata;
    logic        err;
  } host_rsp_t;

  // Device side only sees the word index within its region
  typedef struct packed {
    logic        req;
    logic [7:0]  idx;
    logic        we;
    logic [3:0]  be;
    logic [31:0] wdata;
  } dev_req_t;

  typedef struct packed {
    logic        rvalid;
    logic [31:0] rdata;
  } dev_rsp_t;

  // Record of a granted request, answered one cycle later
  typedef struct packed {
    logic        valid;
    host_e       host;
    target_e     target;
    logic [2:0]  bank;
  } bus_tag_t;

endpackage

// ==== rtl/bus_arbiter.sv ====
/*
 * Fixed-priority arbiter and address decoder for the two bus hosts.
 * Grants combinationally, fans the request out to one device and tags it.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module bus_arbiter import sys_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  host_req_t host_req_i [2],
  output logic      host_gnt_o [2],
  output dev_req_t  bank_req_o [`NUM_RAM_BANKS],
  output dev_req_t  ctrl_req_o,
  output bus_tag_t  tag_o
);

  localparam logic [31:0] RamBase     = `RAM_BASE;
  localparam logic [31:0] RamSpan     = `NUM_RAM_BANKS * `BANK_BYTES;
  localparam logic [31:0] SimCtrlBase = `SIMCTRL_BASE;

  host_e       win_host;
  host_req_t   win_req;
  logic [31:0] ram_ofs;
  logic [2:0]  bank_idx;
  target_e     tgt;
  dev_req_t    fwd;

  // Clock and reset only reach the bound protocol checks
  logic unused_clk_rst;
  assign unused_clk_rst = clk_i ^ rst_i;

  // Data port always beats instruction port
  always_comb begin
    if (host_req_i[HostD].req) begin
      win_host = HostD;
    end else begin
      win_host = HostI;
    end
    win_req = host_req_i[win_host];
  end

  // Address decode of the winning request
  always_comb begin
    ram_ofs  = win_req.addr - RamBase;
    bank_idx = ram_ofs[12:10];
    if (win_req.addr >= RamBase && ram_ofs < RamSpan) begin
      tgt = TgtRam;
    end else if (win_req.addr[31:10] == SimCtrlBase[31:10]) begin
      tgt = TgtSimCtrl;
    end else begin
      tgt = TgtNone;
    end
  end

  // Word index is the same for every device
  always_comb begin
    fwd.req   = win_req.req;
    fwd.idx   = win_req.addr[9:2];
    fwd.we    = win_req.we;
    fwd.be    = win_req.be;
    fwd.wdata = win_req.wdata;
  end

  always_comb begin
    host_gnt_o[HostD] = host_req_i[HostD].req;
    host_gnt_o[HostI] = host_req_i[HostI].req && !host_req_i[HostD].req;
  end

  // Only the selected device sees req
  always_comb begin
    for (int k = 0; k < `NUM_RAM_BANKS; k++) begin
      bank_req_o[k]     = fwd;
      bank_req_o[k].req = fwd.req && (tgt == TgtRam) && (bank_idx == 3'(k));
    end
    ctrl_req_o     = fwd;
    ctrl_req_o.req = fwd.req && (tgt == TgtSimCtrl);
  end

  // Unmapped accesses are tagged too, resp_mux answers them with err
  always_comb begin
    tag_o.valid  = win_req.req;
    tag_o.host   = win_host;
    tag_o.target = tgt;
    if (tgt == TgtRam) begin
      tag_o.bank = bank_idx;
    end else begin
      tag_o.bank = 3'd0;
    end
  end

endmodule

// ==== rtl/ram_1p.sv ====
/*
 * Single-port SRAM bank, word addressed, with byte enables.
 * Answers each request one cycle later; write responses carry stale data.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module ram_1p import sys_pkg::*; (
  input  logic     clk_i,
  input  logic     rst_i,
  input  dev_req_t req_i,
  output dev_rsp_t rsp_o
);

  logic [31:0] mem [`BANK_WORDS];
  logic [31:0] rdata_q;
  logic        rvalid_q;

  // Storage and read port
  always_ff @(posedge clk_i) begin
    if (req_i.req) begin
      if (req_i.we) begin
        for (int b = 0; b < 4; b++) begin
          if (req_i.be[b]) begin
            mem[req_i.idx][8*b +: 8] <= req_i.wdata[8*b +: 8];
          end
        end
      end
      rdata_q <= mem[req_i.idx];
    end
  end

  // One response per accepted request
  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      rvalid_q <= 1'b0;
    end else begin
      rvalid_q <= req_i.req;
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;

endmodule

// ==== rtl/sim_ctrl.sv ====
/*
 * Simulation control device: character output, character count and halt flag.
 * Any read returns the count in bits 7:0 and halt in bit 8.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module sim_ctrl import sys_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  dev_req_t   req_i,
  output dev_rsp_t   rsp_o,
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  localparam logic [7:0] CharIdx = 8'(`SIMCTRL_CHAR_OFS >> 2);
  localparam logic [7:0] HaltIdx = 8'(`SIMCTRL_HALT_OFS >> 2);

  logic        char_wr;
  logic        halt_wr;
  logic        char_valid_q;
  logic [7:0]  char_q;
  logic [7:0]  count_q;
  logic        halt_q;
  logic        rvalid_q;
  logic [31:0] rdata_q;

  assign char_wr = req_i.req && req_i.we && (req_i.idx == CharIdx) && req_i.be[0];
  assign halt_wr = req_i.req && req_i.we && (req_i.idx == HaltIdx) && (|req_i.wdata);

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      char_valid_q <= 1'b0;
      count_q      <= 8'd0;
      halt_q       <= 1'b0;
      rvalid_q     <= 1'b0;
    end else begin
      char_valid_q <= char_wr;
      rvalid_q     <= req_i.req;
      if (char_wr) begin
        count_q <= count_q + 8'd1;
      end
      // Sticky until reset
      if (halt_wr) begin
        halt_q <= 1'b1;
      end
    end
  end

  // Character byte and status word
  always_ff @(posedge clk_i) begin
    if (char_wr) begin
      char_q <= req_i.wdata[7:0];
    end
    if (req_i.req) begin
      rdata_q <= {23'd0, halt_q, count_q};
    end
  end

  assign rsp_o.rvalid = rvalid_q;
  assign rsp_o.rdata  = rdata_q;
  assign char_valid_o = char_valid_q;
  assign char_o       = char_q;
  assign halt_o       = halt_q;

endmodule

// ==== rtl/resp_mux.sv ====
/*
 * Response multiplexer: holds the tag of the last grant for one cycle
 * and steers the matching device response, or an error, to its host.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module resp_mux import sys_pkg::*; (
  input  logic      clk_i,
  input  logic      rst_i,
  input  bus_tag_t  tag_i,
  input  dev_rsp_t  bank_rsp_i [`NUM_RAM_BANKS],
  input  dev_rsp_t  ctrl_rsp_i,
  output host_rsp_t host_rsp_o [2]
);

  bus_tag_t    tag_q;
  dev_rsp_t    bank_sel;
  logic        rsp_ok;
  logic        rsp_err;
  logic [31:0] rsp_rdata;

  always_ff @(posedge clk_i) begin
    if (rst_i) begin
      tag_q <= '0;
    end else begin
      tag_q <= tag_i;
    end
  end

  // Bank recorded at grant time
  always_comb begin
    bank_sel = '0;
    for (int k = 0; k < `NUM_RAM_BANKS; k++) begin
      if (tag_q.bank == 3'(k)) begin
        bank_sel = bank_rsp_i[k];
      end
    end
  end

  always_comb begin
    case (tag_q.target)
      TgtRam: begin
        rsp_ok    = bank_sel.rvalid;
        rsp_rdata = bank_sel.rdata;
        rsp_err   = 1'b0;
      end
      TgtSimCtrl: begin
        rsp_ok    = ctrl_rsp_i.rvalid;
        rsp_rdata = ctrl_rsp_i.rdata;
        rsp_err   = 1'b0;
      end
      // No device behind this address
      default: begin
        rsp_ok    = 1'b1;
        rsp_rdata = 32'd0;
        rsp_err   = 1'b1;
      end
    endcase
  end

  // gnt is merged in at the top level
  always_comb begin
    for (int h = 0; h < 2; h++) begin
      host_rsp_o[h].gnt    = 1'b0;
      host_rsp_o[h].rvalid = tag_q.valid && rsp_ok && (tag_q.host == host_e'(h));
      host_rsp_o[h].rdata  = rsp_rdata;
      host_rsp_o[h].err    = host_rsp_o[h].rvalid && rsp_err;
    end
  end

endmodule

// ==== rtl/simple_system.sv ====
/*
 * Simple bus system: two external hosts reach the RAM banks and the
 * simulation control block through the arbiter and the response mux.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module simple_system import sys_pkg::*; (
  input  logic       clk_i,
  input  logic       rst_i,
  input  host_req_t  host_req_i [2],
  output host_rsp_t  host_rsp_o [2],
  output logic       char_valid_o,
  output logic [7:0] char_o,
  output logic       halt_o
);

  logic      host_gnt [2];
  host_rsp_t mux_rsp  [2];
  dev_req_t  bank_req [`NUM_RAM_BANKS];
  dev_rsp_t  bank_rsp [`NUM_RAM_BANKS];
  dev_req_t  ctrl_req;
  dev_rsp_t  ctrl_rsp;
  bus_tag_t  tag;

  bus_arbiter u_arbiter (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .host_req_i (host_req_i),
    .host_gnt_o (host_gnt),
    .bank_req_o (bank_req),
    .ctrl_req_o (ctrl_req),
    .tag_o      (tag)
  );

  // One SRAM bank per kB of the RAM region
  for (genvar k = 0; k < `NUM_RAM_BANKS; k++) begin : g_bank
    ram_1p u_ram (
      .clk_i (clk_i),
      .rst_i (rst_i),
      .req_i (bank_req[k]),
      .rsp_o (bank_rsp[k])
    );
  end

  sim_ctrl u_sim_ctrl (
    .clk_i        (clk_i),
    .rst_i        (rst_i),
    .req_i        (ctrl_req),
    .rsp_o        (ctrl_rsp),
    .char_valid_o (char_valid_o),
    .char_o       (char_o),
    .halt_o       (halt_o)
  );

  resp_mux u_resp_mux (
    .clk_i      (clk_i),
    .rst_i      (rst_i),
    .tag_i      (tag),
    .bank_rsp_i (bank_rsp),
    .ctrl_rsp_i (ctrl_rsp),
    .host_rsp_o (mux_rsp)
  );

  // Grant comes straight from the arbiter, the rest from the mux
  for (genvar h = 0; h < 2; h++) begin : g_host
    assign host_rsp_o[h].gnt    = host_gnt[h];
    assign host_rsp_o[h].rvalid = mux_rsp[h].rvalid;
    assign host_rsp_o[h].rdata  = mux_rsp[h].rdata;
    assign host_rsp_o[h].err    = mux_rsp[h].err;
  end

endmodule

// ==== bench/simple_system_properties.sv ====
/*
 * Bus protocol assertions, bound to the simple system top level.
 */
`timescale 1ns/1ps

module simple_system_properties import sys_pkg::*; (
  input logic      clk_i,
  input logic      rst_i,
  input host_rsp_t host_rsp_o [2],
  input logic      halt_o
);

  // Fixed priority never grants both hosts
  assert property (@(posedge clk_i) disable iff (rst_i)
    !(host_rsp_o[0].gnt && host_rsp_o[1].gnt))
    else $error("both hosts granted in one cycle");

  // Response exactly one cycle after each grant
  assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_o[0].gnt |=> host_rsp_o[0].rvalid)
    else $error("data port grant without response");
  assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_o[1].gnt |=> host_rsp_o[1].rvalid)
    else $error("instruction port grant without response");
  assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_o[0].rvalid |-> $past(host_rsp_o[0].gnt))
    else $error("data port response without grant");
  assert property (@(posedge clk_i) disable iff (rst_i)
    host_rsp_o[1].rvalid |-> $past(host_rsp_o[1].gnt))
    else $error("instruction port response without grant");

  assert property (@(posedge clk_i) disable iff (rst_i)
    $past(halt_o) |-> halt_o)
    else $error("halt flag fell without reset");

endmodule

bind simple_system simple_system_properties u_props (
  .clk_i      (clk_i),
  .rst_i      (rst_i),
  .host_rsp_o (host_rsp_o),
  .halt_o     (halt_o)
);

// ==== bench/tb_simple_system.sv ====
/*
 * Testbench for the simple system: plays both bus hosts from a stimulus
 * table and checks responses, character output and halt against a model.
 */
`timescale 1ns/1ps
`include "sys_macros.svh"

module tb_simple_system import sys_pkg::*; ();

  localparam int TimeoutCycles = 20;

  typedef struct packed {
    host_e       host;
    logic        we;
    logic [31:0] addr;
    logic [3:0]  be;
    logic [31:0] wdata;
    logic [31:0] exp_rdata;
    logic        exp_err;
  } stim_t;

  logic        clk = 1'b0;
  logic        rst;
  host_req_t   req [2];
  host_rsp_t   rsp [2];
  logic        char_valid;
  logic [7:0]  char_byte;
  logic        halt;
  int          errors = 0;
  logic [31:0] lfsr_q = 32'd69;
  stim_t       stim_q [$];
  logic [31:0] model [logic [31:0]];
  logic [7:0]  char_count = 8'd0;
  logic        halt_exp = 1'b0;

  simple_system simple_system_i (
    .clk_i        (clk),
    .rst_i        (rst),
    .host_req_i   (req),
    .host_rsp_o   (rsp),
    .char_valid_o (char_valid),
    .char_o       (char_byte),
    .halt_o       (halt)
  );

  always #20 clk = ~clk;

  function automatic logic [31:0] lfsr_next(input logic [31:0] s);
    return s[0] ? ((s >> 1) ^ 32'hA300_0000) : (s >> 1);
  endfunction

  // One LFSR step per bit taken
  task automatic rand_bits(input int n, output logic [31:0] v);
    v = '0;
    for (int i = 0; i < n; i++) begin
      v = {v[30:0], lfsr_q[0]};
      lfsr_q = lfsr_next(lfsr_q);
    end
  endtask

  task automatic check_equal(input string name, input logic [31:0] got,
                             input logic [31:0] exp);
    if (got !== exp) begin
      $display("Error: %s expected 0x%08h got 0x%08h", name, exp, got);
      errors++;
    end
  endtask

  // Expected response follows the address map and device rules
  task automatic add_entry(input host_e h, input logic we, input logic [31:0] a,
                           input logic [3:0] be, input logic [31:0] wd);
    stim_t s;
    logic [31:0] ofs;
    s = '{host: h, we: we, addr: a, be: be, wdata: wd, exp_rdata: '0, exp_err: 1'b0};
    ofs = a - `SIMCTRL_BASE;
    if (a >= `RAM_BASE && a < `RAM_BASE + `NUM_RAM_BANKS * 1024) begin
      if (we) begin
        for (int b = 0; b < 4; b++) begin
          if (be[b]) model[a][8*b +: 8] = wd[8*b +: 8];
        end
      end
      s.exp_rdata = model[a];
    end else if (a >= `SIMCTRL_BASE && ofs < `SIMCTRL_SIZE) begin
      if (we && ofs[9:2] == 8'(`SIMCTRL_CHAR_OFS >> 2) && be[0]) char_count++;
      if (we && ofs[9:2] == 8'(`SIMCTRL_HALT_OFS >> 2) && wd != 0) halt_exp = 1'b1;
      s.exp_rdata = {23'd0, halt_exp, char_count};
    end else begin
      s.exp_err = 1'b1;
    end
    stim_q.push_back(s);
  endtask

  task automatic wait_gnt(input host_e h, output int n);
    n = 0;
    @(posedge clk);
    while (!rsp[h].gnt && n < TimeoutCycles) begin
      n++;
      @(posedge clk);
    end
    if (!rsp[h].gnt) begin
      $display("Timeout while waiting for a bus grant");
      errors++;
    end
  endtask

  task automatic check_rsp(input stim_t s);
    check_equal("rvalid", 32'(rsp[s.host].rvalid), 32'd1);
    check_equal("err", 32'(rsp[s.host].err), 32'(s.exp_err));
    if (!s.we || s.exp_err) check_equal("rdata", rsp[s.host].rdata, s.exp_rdata);
  endtask

  task automatic run_access(input stim_t s);
    int n;
    @(negedge clk);
    req[s.host] = '{req: 1'b1, addr: s.addr, we: s.we, be: s.be, wdata: s.wdata};
    wait_gnt(s.host, n);
    @(negedge clk);
    req[s.host].req = 1'b0;
    check_rsp(s);
    if (s.we && s.addr == `SIMCTRL_BASE + `SIMCTRL_CHAR_OFS && s.be[0]) begin
      check_equal("char_valid_o", 32'(char_valid), 32'd1);
      check_equal("char_o", 32'(char_byte), 32'(s.wdata[7:0]));
    end
  endtask

  // Both hosts in the same cycle, data port first
  task automatic run_contention(input stim_t sd, input stim_t si);
    int n;
    @(negedge clk);
    req[HostD] = '{req: 1'b1, addr: sd.addr, we: 1'b0, be: 4'hf, wdata: '0};
    req[HostI] = '{req: 1'b1, addr: si.addr, we: 1'b0, be: 4'hf, wdata: '0};
    wait_gnt(HostD, n);
    check_equal("gnt HostI", 32'(rsp[HostI].gnt), 32'd0);
    @(negedge clk);
    req[HostD].req = 1'b0;
    check_rsp(sd);
    check_equal("rvalid HostI", 32'(rsp[HostI].rvalid), 32'd0);
    wait_gnt(HostI, n);
    if (n != 0) begin
      $display("HostI was not granted in the cycle after HostD");
      errors++;
    end
    @(negedge clk);
    req[HostI].req = 1'b0;
    check_rsp(si);
  endtask

  initial begin
    logic [31:0] a;
    logic [31:0] w;
    req[0] = '0;
    req[1] = '0;
    rst = 1'b1;
    for (int i = 0; i < 5; i++) begin
      @(negedge clk);
      if (i > 0) begin
        check_equal("gnt", 32'({rsp[0].gnt, rsp[1].gnt}), 32'd0);
        check_equal("rvalid", 32'({rsp[0].rvalid, rsp[1].rvalid}), 32'd0);
        check_equal("char_valid_o", 32'(char_valid), 32'd0);
        check_equal("halt_o", 32'(halt), 32'd0);
      end
    end
    rst = 1'b0;
    @(negedge clk);
    check_equal("rvalid", 32'({rsp[0].rvalid, rsp[1].rvalid}), 32'd0);
    check_equal("halt_o", 32'(halt), 32'd0);

    // Same word in every bank, so a wrong bank decode shows up later
    for (int k = 0; k < `NUM_RAM_BANKS; k++) begin
      a = `RAM_BASE + k * 1024 + 4 * 45;
      rand_bits(32, w);
      add_entry(HostD, 1'b1, a, 4'hf, w);
      rand_bits(32, w);
      add_entry(HostI, 1'b1, a, 4'(k + 1), w);
      add_entry(HostI, 1'b0, a, 4'hf, '0);
      add_entry(HostD, 1'b0, a, 4'hf, '0);
    end
    rand_bits(32, w);
    add_entry(HostD, 1'b1, 32'h0000_4000, 4'hf, w);
    add_entry(HostI, 1'b0, 32'h0000_4000, 4'hf, '0);
    add_entry(HostD, 1'b0, `RAM_BASE + `NUM_RAM_BANKS * 1024, 4'hf, '0);
    for (int i = 0; i < 3; i++) begin
      rand_bits(24, w);
      add_entry(HostD, 1'b1, `SIMCTRL_BASE + `SIMCTRL_CHAR_OFS, 4'h1, {w[23:0], 8'(8'h41 + i)});
    end
    add_entry(HostI, 1'b0, `SIMCTRL_BASE + `SIMCTRL_CHAR_OFS, 4'hf, '0);
    add_entry(HostD, 1'b1, `SIMCTRL_BASE + `SIMCTRL_HALT_OFS, 4'hf, 32'h1);
    add_entry(HostD, 1'b0, `SIMCTRL_BASE + `SIMCTRL_HALT_OFS, 4'hf, '0);

    foreach (stim_q[i]) run_access(stim_q[i]);
    // Data port reads bank 0, instruction port reads bank 1
    run_contention(stim_q[3], stim_q[6]);
    check_equal("halt_o", 32'(halt), 32'd1);

    $display("Checks done with %0d errors", errors);
    if (errors == 0) begin
      $display("NO ERRORS");
    end else begin
      $display("ERRORS FOUND");
    end
    $finish;
  end

endmodule

// ==== project.f ====
+incdir+rtl
rtl/sys_pkg.sv
rtl/bus_arbiter.sv
rtl/ram_1p.sv
rtl/sim_ctrl.sv
rtl/resp_mux.sv
rtl/simple_system.sv
bench/simple_system_properties.sv
bench/tb_simple_system.sv

// ==== Makefile ====
# Verilator build and run of the simple system testbench

VERILATOR ?= verilator
VFLAGS    ?= --binary --timing --assert -j 0
LINTFLAGS ?= --lint-only --timing -Wall
TOP       ?= tb_simple_system
RTL_TOP   ?= simple_system
FILELIST  ?= project.f
OBJDIR    ?= obj_dir
LOG       ?= sim.log

.PHONY: all build run lint clean

all: run

build:
	$(VERILATOR) $(VFLAGS) -f $(FILELIST) --top-module $(TOP) --Mdir $(OBJDIR)

run: build
	-./$(OBJDIR)/V$(TOP) > $(LOG) 2>&1
	cat $(LOG)
	grep -q "NO ERRORS" $(LOG)

lint:
	$(VERILATOR) $(LINTFLAGS) -f $(FILELIST) --top-module $(TOP)

clean:
	rm -rf $(OBJDIR) $(LOG)
